//--- Makefile
TOP := tb_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- design/axil_reg_bridge.sv
/*
 * AXI4-Lite to register bridge
 * Accepts one transaction at a time, issues a single-cycle register
 * request and holds the registered response until the host takes it
 */

`default_nettype none

`include "soc_params.svh"

module axil_reg_bridge import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } state_e;

  state_e                 state_q;
  logic                   is_read_q;
  logic [1:0]             resp_q;
  logic [`SOC_DATA_W-1:0] rdata_q;

  logic accept_rd;
  logic accept_wr;
  logic resp_done;

  //////////////////////////////////////////////////////////////////////
  // Acceptance

  // Read has priority, write needs address and data together
  assign accept_rd = (state_q == ST_IDLE) && axil_req_i.ar_valid;
  assign accept_wr = (state_q == ST_IDLE) && !axil_req_i.ar_valid &&
                     axil_req_i.aw_valid && axil_req_i.w_valid;

  assign resp_done = (state_q == ST_RESP) &&
                     (is_read_q ? axil_req_i.r_ready : axil_req_i.b_ready);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      is_read_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept_rd || accept_wr) begin
            state_q   <= ST_RESP;
            is_read_q <= accept_rd;
          end
        end
        ST_RESP: begin
          if (resp_done) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Capture the register answer in the accept cycle
  always_ff @(posedge clk_i) begin
    if (accept_rd || accept_wr) begin
      rdata_q <= reg_rsp_i.rdata;
      resp_q  <= reg_rsp_i.error ? RESP_SLVERR : RESP_OKAY;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register request

  always_comb begin
    reg_req_o.valid = accept_rd || accept_wr;
    reg_req_o.write = accept_wr;
    reg_req_o.addr  = accept_rd ? axil_req_i.ar_addr : axil_req_i.aw_addr;
    reg_req_o.wdata = axil_req_i.w_data;
    reg_req_o.wstrb = axil_req_i.w_strb;
  end

  //////////////////////////////////////////////////////////////////////
  // Host response

  always_comb begin
    axil_rsp_o.aw_ready = accept_wr;
    axil_rsp_o.w_ready  = accept_wr;
    axil_rsp_o.ar_ready = accept_rd;
    // Held response drives the channel it belongs to
    axil_rsp_o.b_valid  = (state_q == ST_RESP) && !is_read_q;
    axil_rsp_o.b_resp   = resp_q;
    axil_rsp_o.r_valid  = (state_q == ST_RESP) && is_read_q;
    axil_rsp_o.r_data   = rdata_q;
    axil_rsp_o.r_resp   = resp_q;
  end

endmodule

`default_nettype wire

//--- design/soc_pkg.sv
/*
 * SoC package
 * AXI4-Lite and register bus structs, register offsets and response codes
 */

`default_nettype none

`include "soc_params.svh"

package soc_pkg;

  // Host side of the AXI4-Lite port
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0]   aw_addr;
    logic                     aw_valid;
    logic [`SOC_DATA_W-1:0]   w_data;
    logic [`SOC_DATA_W/8-1:0] w_strb;
    logic                     w_valid;
    logic                     b_ready;
    logic [`SOC_ADDR_W-1:0]   ar_addr;
    logic                     ar_valid;
    logic                     r_ready;
  } axil_req_t;

  // Slave side of the AXI4-Lite port
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    logic [1:0]             b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [`SOC_DATA_W-1:0] r_data;
    logic [1:0]             r_resp;
  } axil_rsp_t;

  // Single-cycle register request and its same-cycle answer
  typedef struct packed {
    logic                     valid;
    logic                     write;
    logic [`SOC_ADDR_W-1:0]   addr;
    logic [`SOC_DATA_W-1:0]   wdata;
    logic [`SOC_DATA_W/8-1:0] wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   error;
  } reg_rsp_t;

  localparam logic [`SOC_ADDR_W-1:0] REG_SCRATCH = `SOC_ADDR_W'('h00);
  localparam logic [`SOC_ADDR_W-1:0] REG_RTC     = `SOC_ADDR_W'('h04);
  localparam logic [`SOC_ADDR_W-1:0] REG_UART_TX = `SOC_ADDR_W'('h08);
  localparam logic [`SOC_ADDR_W-1:0] REG_STATUS  = `SOC_ADDR_W'('h0C);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- design/soc_regs.sv
/*
 * SoC register block
 * Scratch register, real-time counter, UART transmit push and status
 */

`default_nettype none

`include "soc_params.svh"

module soc_regs import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  reg_req_t   reg_req_i,
  output reg_rsp_t   reg_rsp_o,
  output logic       push_o,
  output logic [7:0] push_data_o,
  input  logic       fifo_full_i,
  input  logic       fifo_empty_i,
  input  logic       tx_busy_i
);

  localparam int unsigned DIV_W = $clog2(`SOC_RTC_DIV);

  logic [DIV_W-1:0]       div_q;
  logic                   rtc_tick;
  logic [`SOC_DATA_W-1:0] rtc_q;
  logic [`SOC_DATA_W-1:0] scratch_q;
  logic                   scratch_we;

  //////////////////////////////////////////////////////////////////////
  // Real-time tick and counter

  assign rtc_tick = (div_q == DIV_W'(`SOC_RTC_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      div_q <= '0;
      rtc_q <= '0;
    end else begin
      if (rtc_tick) begin
        div_q <= '0;
        rtc_q <= rtc_q + 1'b1;
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    push_o          = 1'b0;
    scratch_we      = 1'b0;
    case (reg_req_i.addr)
      REG_SCRATCH: begin
        if (reg_req_i.write) begin
          scratch_we = reg_req_i.valid;
        end else begin
          reg_rsp_o.rdata = scratch_q;
        end
      end
      REG_RTC: begin
        if (reg_req_i.write) begin
          reg_rsp_o.error = 1'b1;
        end else begin
          reg_rsp_o.rdata = rtc_q;
        end
      end
      REG_UART_TX: begin
        // Write only, byte dropped when the queue is full
        if (!reg_req_i.write || fifo_full_i) begin
          reg_rsp_o.error = 1'b1;
        end else begin
          push_o = reg_req_i.valid;
        end
      end
      REG_STATUS: begin
        if (reg_req_i.write) begin
          reg_rsp_o.error = 1'b1;
        end else begin
          reg_rsp_o.rdata[2:0] = {tx_busy_i, fifo_empty_i, fifo_full_i};
        end
      end
      default: reg_rsp_o.error = 1'b1;
    endcase
  end

  assign push_data_o = reg_req_i.wdata[7:0];

  // Scratch storage with byte strobes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scratch_q <= '0;
    end else if (scratch_we) begin
      for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
        if (reg_req_i.wstrb[b]) begin
          scratch_q[b*8 +: 8] <= reg_req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/soc_wrapper.sv
/*
 * SoC top level
 * AXI4-Lite host port in, register block with transmit queue, UART line out
 */

`default_nettype none

module soc_wrapper import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output logic      uart_tx_o
);

  reg_req_t   reg_req;
  reg_rsp_t   reg_rsp;
  logic       push;
  logic [7:0] push_data;
  logic       fifo_full;
  logic       fifo_empty;
  logic [7:0] fifo_data;
  logic       pop;
  logic       tx_busy;

  //////////////////////////////////////////////////////////////////////
  // Host port and registers

  axil_reg_bridge i_bridge (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .axil_req_i ( axil_req_i ),
    .axil_rsp_o ( axil_rsp_o ),
    .reg_req_o  ( reg_req    ),
    .reg_rsp_i  ( reg_rsp    )
  );

  soc_regs i_regs (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .reg_req_i    ( reg_req    ),
    .reg_rsp_o    ( reg_rsp    ),
    .push_o       ( push       ),
    .push_data_o  ( push_data  ),
    .fifo_full_i  ( fifo_full  ),
    .fifo_empty_i ( fifo_empty ),
    .tx_busy_i    ( tx_busy    )
  );

  //////////////////////////////////////////////////////////////////////
  // Transmit path

  tx_byte_fifo i_tx_fifo (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .push_i  ( push       ),
    .data_i  ( push_data  ),
    .pop_i   ( pop        ),
    .data_o  ( fifo_data  ),
    .full_o  ( fifo_full  ),
    .empty_o ( fifo_empty )
  );

  uart_tx i_uart_tx (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .fifo_empty_i ( fifo_empty ),
    .fifo_data_i  ( fifo_data  ),
    .pop_o        ( pop        ),
    .busy_o       ( tx_busy    ),
    .tx_o         ( uart_tx_o  )
  );

endmodule

`default_nettype wire

//--- design/tx_byte_fifo.sv
/*
 * Transmit byte queue
 * Synchronous circular buffer with full and empty flags
 */

`default_nettype none

`include "soc_params.svh"

module tx_byte_fifo (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       push_i,
  input  logic [7:0] data_i,
  input  logic       pop_i,
  output logic [7:0] data_o,
  output logic       full_o,
  output logic       empty_o
);

  localparam int unsigned PTR_W = $clog2(`SOC_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`SOC_FIFO_DEPTH + 1);

  logic [7:0]       mem_q [`SOC_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(`SOC_FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`SOC_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`SOC_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
/*
 * UART transmitter, 8N1
 * Pops a byte from the queue when idle and shifts out start, data, stop
 */

`default_nettype none

`include "soc_params.svh"

module uart_tx (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       fifo_empty_i,
  input  logic [7:0] fifo_data_i,
  output logic       pop_o,
  output logic       busy_o,
  output logic       tx_o
);

  localparam int unsigned BAUD_W = $clog2(`SOC_BAUD_DIV);

  logic              busy_q;
  logic [BAUD_W-1:0] baud_q;
  logic [3:0]        bit_idx_q;
  logic [9:0]        frame_q;
  logic              bit_end;
  logic              frame_end;

  assign bit_end   = busy_q && (baud_q == BAUD_W'(`SOC_BAUD_DIV - 1));
  assign frame_end = bit_end && (bit_idx_q == 4'd9);

  // Reload straight after the stop bit so frames run back to back
  assign pop_o  = (!busy_q || frame_end) && !fifo_empty_i;
  assign busy_o = busy_q || pop_o;
  assign tx_o   = busy_q ? frame_q[0] : 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      baud_q    <= '0;
      bit_idx_q <= '0;
    end else begin
      if (pop_o) begin
        busy_q    <= 1'b1;
        baud_q    <= '0;
        bit_idx_q <= '0;
      end else if (frame_end) begin
        busy_q <= 1'b0;
      end else if (bit_end) begin
        baud_q    <= '0;
        bit_idx_q <= bit_idx_q + 1'b1;
      end else if (busy_q) begin
        baud_q <= baud_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame shifter, LSB first

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      frame_q <= {1'b1, fifo_data_i, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

endmodule

`default_nettype wire

//--- include/soc_params.svh
/*
 * SoC configuration constants
 * Bus widths, tick and baud dividers, transmit queue depth
 */

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Register bus
`define SOC_ADDR_W 8
`define SOC_DATA_W 32

// System cycles per real-time tick
`define SOC_RTC_DIV 16

// System cycles per UART bit
`define SOC_BAUD_DIV 4

// Transmit queue entries, in bytes
`define SOC_FIFO_DEPTH 4

`endif

//--- sim/soc_properties.sv
/*
 * SoC bus and line checks
 * AXI4-Lite response stability and UART idle level in reset
 */

`default_nettype none

module soc_properties import soc_pkg::*; (
  input logic      clk_i,
  input logic      reset_i,
  input axil_req_t axil_req_i,
  input axil_rsp_t axil_rsp_o,
  input logic      uart_tx_o
);

  // Responses hold until the host takes them
  b_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axil_rsp_o.b_valid && !axil_req_i.b_ready |=> axil_rsp_o.b_valid)
    else $error("b_valid dropped before b_ready");

  r_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axil_rsp_o.r_valid && !axil_req_i.r_ready |=> axil_rsp_o.r_valid)
    else $error("r_valid dropped before r_ready");

  // One transaction at a time
  no_aw_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    (axil_rsp_o.b_valid || axil_rsp_o.r_valid) |-> !axil_rsp_o.aw_ready)
    else $error("aw_ready high while a response is pending");

  uart_idle_in_reset: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> uart_tx_o)
    else $error("uart_tx_o low during reset");

endmodule

bind soc_wrapper soc_properties props0 (.*);

`default_nettype wire

//--- sim/tb_soc.sv
/*
 * SoC testbench
 * Directed AXI4-Lite tests of the register map, RTC and UART path
 */

`default_nettype none

`include "soc_params.svh"

module tb_soc import soc_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int FRAME_CYCLES   = 10 * `SOC_BAUD_DIV;

  logic      clk_i   = 1'b0;
  logic      reset_i = 1'b1;
  axil_req_t req;
  axil_rsp_t rsp;
  logic      uart_tx;

  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          last_accept;
  int          wr_hs_cycle = -1;
  int          rd_hs_cycle = -1;
  // Cycles the host holds b_ready or r_ready low after valid
  int          bp_cycles = 0;
  logic [31:0] lfsr_q = 32'he9d406c2;
  logic [7:0]  rx_q [$];

  soc_wrapper dut0 (
    .clk_i      ( clk_i   ),
    .reset_i    ( reset_i ),
    .axil_req_i ( req     ),
    .axil_rsp_o ( rsp     ),
    .uart_tx_o  ( uart_tx )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors %0d, checks %0d", errors, checks);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Cycle of the latest write and read address handshakes
  always @(posedge clk_i) begin
    if (req.aw_valid && req.w_valid && rsp.aw_ready && rsp.w_ready) begin
      wr_hs_cycle <= cycles;
    end
    if (req.ar_valid && rsp.ar_ready) begin
      rd_hs_cycle <= cycles;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Called and returning on a falling edge
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    req.aw_addr  = addr;
    req.aw_valid = 1'b1;
    req.w_data   = data;
    req.w_strb   = strb;
    req.w_valid  = 1'b1;
    req.b_ready  = (bp_cycles == 0);
    @(negedge clk_i);
    while (!rsp.b_valid) @(negedge clk_i);
    last_accept  = cycles;
    checks++;
    if (wr_hs_cycle != cycles - 1) begin
      $display("Write handshake was not seen in the cycle before b_valid rose");
      errors++;
    end
    resp         = rsp.b_resp;
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    repeat (bp_cycles) begin
      @(negedge clk_i);
      checks++;
      if (!rsp.b_valid || rsp.b_resp !== resp) begin
        $display("Write response did not hold while b_ready was low");
        errors++;
      end
    end
    req.b_ready = 1'b1;
    @(negedge clk_i);
    req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    req.ar_addr  = addr;
    req.ar_valid = 1'b1;
    req.r_ready  = (bp_cycles == 0);
    @(negedge clk_i);
    while (!rsp.r_valid) @(negedge clk_i);
    last_accept  = cycles;
    checks++;
    if (rd_hs_cycle != cycles - 1) begin
      $display("Read handshake was not seen in the cycle before r_valid rose");
      errors++;
    end
    data         = rsp.r_data;
    resp         = rsp.r_resp;
    req.ar_valid = 1'b0;
    repeat (bp_cycles) begin
      @(negedge clk_i);
      checks++;
      if (!rsp.r_valid || rsp.r_resp !== resp || rsp.r_data !== data) begin
        $display("Read response did not hold while r_ready was low");
        errors++;
      end
    end
    req.r_ready = 1'b1;
    @(negedge clk_i);
    req.r_ready = 1'b0;
  endtask

  // Line decoder, samples each bit in its middle
  initial begin : line_decoder
    logic [7:0] byte_v;
    wait (!reset_i);
    forever begin
      @(negedge clk_i);
      if (uart_tx == 1'b0) begin
        repeat (`SOC_BAUD_DIV / 2) @(negedge clk_i);
        if (uart_tx !== 1'b0) begin
          $display("UART start bit did not stay low to its middle");
          errors++;
        end
        for (int i = 0; i < 8; i++) begin
          repeat (`SOC_BAUD_DIV) @(negedge clk_i);
          byte_v[i] = uart_tx;
        end
        repeat (`SOC_BAUD_DIV) @(negedge clk_i);
        if (uart_tx !== 1'b1) begin
          $display("UART stop bit was low in byte 0x%02h", byte_v);
          errors++;
        end
        rx_q.push_back(byte_v);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset_state();
    logic [31:0] d;
    logic [1:0]  r;
    expect_word("uart_tx_o", uart_tx, 32'h1);
    axil_read(REG_STATUS, d, r);
    expect_word("status r_resp", r, RESP_OKAY);
    // Queue empty, not full, transmitter idle
    expect_word("status r_data", d, 32'h2);
    axil_read(REG_SCRATCH, d, r);
    expect_word("scratch r_resp", r, RESP_OKAY);
    expect_word("scratch r_data", d, 32'h0);
  endtask

  task automatic test_scratch();
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] model;
    logic [31:0] d;
    logic [1:0]  r;
    model = '0;
    for (int n = 0; n < 12; n++) begin
      bp_cycles = n % 3;
      draw_bits(32, data);
      draw_bits(4, strb);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) model[b*8 +: 8] = data[b*8 +: 8];
      end
      axil_write(REG_SCRATCH, data, strb[3:0], r);
      expect_word("scratch b_resp", r, RESP_OKAY);
      axil_read(REG_SCRATCH, d, r);
      expect_word("scratch r_resp", r, RESP_OKAY);
      expect_word("scratch r_data", d, model);
    end
    bp_cycles = 0;
  endtask

  task automatic test_bad_access();
    logic [31:0] d;
    logic [1:0]  r;
    axil_read(8'h10, d, r);
    expect_word("unmapped r_resp", r, RESP_SLVERR);
    expect_word("unmapped r_data", d, 32'h0);
    axil_read(REG_UART_TX, d, r);
    expect_word("uart_tx read r_resp", r, RESP_SLVERR);
    expect_word("uart_tx read r_data", d, 32'h0);
    axil_write(REG_RTC, 32'h5a5a_0001, 4'hf, r);
    expect_word("rtc write b_resp", r, RESP_SLVERR);
    axil_write(8'h20, 32'h0000_00ff, 4'hf, r);
    expect_word("unmapped b_resp", r, RESP_SLVERR);
  endtask

  task automatic test_uart();
    logic [31:0] v;
    logic [1:0]  r;
    logic [7:0]  sent_q [$];
    int          refused;
    int          waited;
    refused = 0;
    waited  = 0;
    rx_q.delete();
    for (int i = 0; i < 8; i++) begin
      draw_bits(8, v);
      axil_write(REG_UART_TX, v, 4'hf, r);
      if (r == RESP_OKAY) sent_q.push_back(v[7:0]);
      else refused++;
    end
    if (refused == 0) begin
      $display("No UART write was refused although the queue must have filled");
      errors++;
    end
    while (rx_q.size() < sent_q.size() && waited < 12 * FRAME_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    // Room for any byte that should not be there
    repeat (2 * FRAME_CYCLES) @(negedge clk_i);
    expect_word("uart byte count", rx_q.size(), sent_q.size());
    for (int i = 0; i < sent_q.size() && i < rx_q.size(); i++) begin
      expect_word("uart byte", rx_q[i], sent_q[i]);
    end
  endtask

  task automatic test_rtc();
    logic [31:0] gap;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [1:0]  r;
    int          c0;
    int          k;
    draw_bits(6, gap);
    axil_read(REG_RTC, t0, r);
    expect_word("rtc r_resp", r, RESP_OKAY);
    c0 = last_accept;
    repeat (100 + gap) @(negedge clk_i);
    axil_read(REG_RTC, t1, r);
    k = last_accept - c0;
    checks++;
    if (t1 - t0 != k / `SOC_RTC_DIV && t1 - t0 != k / `SOC_RTC_DIV + 1) begin
      $display("ERROR rtc delta: got 0x%08h over %0d cycles", t1 - t0, k);
      errors++;
    end
  endtask

  initial begin
    req = '0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    test_reset_state();
    test_scratch();
    test_bad_access();
    test_uart();
    test_rtc();
    $display("errors %0d, checks %0d", errors, checks);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/soc_pkg.sv
design/tx_byte_fifo.sv
design/uart_tx.sv
design/axil_reg_bridge.sv
design/soc_regs.sv
design/soc_wrapper.sv
sim/soc_properties.sv
sim/tb_soc.sv
